//--- common/hostWordPkg.sv
// Host command word types
package hostWordPkg;

  // --------------------
  // Kind codes, top two bits of every host word
  // --------------------
  typedef enum logic [1:0] {
    kindChip    = 2'b00,  // Word for the chip
    kindConfig  = 2'b10,  // Register write
    kindChannel = 2'b11   // Channel word, not used here
  } wordKindT;

  // Register write view
  typedef struct packed {
    wordKindT    kind;
    logic [5:0]  regId;   // Register id
    logic [7:0]  pad;
    logic [15:0] data;    // Register value
  } configWordT;

  // Chip command view
  typedef struct packed {
    wordKindT    kind;
    logic [5:0]  leaf;     // Leaf code
    logic [3:0]  pad;
    logic [19:0] payload;  // Leaf payload
  } chipCmdWordT;

  // --------------------
  // One 32-bit word, two readings
  // --------------------
  // Kind sits in the same place in both views,
  // so either member can be used to read it
  typedef union packed {
    configWordT  cfg;
    chipCmdWordT chip;
  } hostWordU;

  // Register ids
  localparam logic [5:0] ctrlRegId = 6'd31;  // Reset control
  localparam logic [5:0] nopRegId  = 6'd63;  // Unused, target of nop fill words

endpackage

//--- common/chipLinkPkg.sv
// Chip link word formats
package chipLinkPkg;

  // --------------------
  // Downstream, toward the chip
  // --------------------
  typedef struct packed {
    logic [5:0]  leaf;     // Leaf code
    logic [19:0] payload;  // Leaf payload
  } chipDownT;

  // --------------------
  // Upstream, from the chip
  // --------------------
  // 34 bits, split at bit 24 for the host
  typedef struct packed {
    logic [9:0]  hi;  // Bits 33..24
    logic [23:0] lo;  // Bits 23..0
  } chipUpT;

  // Host side word built from half a chip word
  typedef struct packed {
    logic [7:0]  header;  // Always upHeader
    logic [23:0] body;
  } hostUpWordT;

  localparam logic [7:0] upHeader = 8'hff;  // Marks upstream data words

endpackage

//--- design/hostWordDecoder.sv
// Host word decoder
`timescale 1ns/100ps

module hostWordDecoder
  import hostWordPkg::*;
  import chipLinkPkg::*;
(
  input  logic     sysClk,
  input  logic     rstN,
  // Host write side
  input  logic     hostInWrite,
  input  hostWordU hostInData,
  // Downstream FIFO
  input  logic     fifoFull,
  output logic     push,
  output chipDownT pushData,
  // Control register outputs
  output logic     pReset,
  output logic     sReset,
  output logic     linkHold
);

  // Register 31, bit 0 pReset, bit 1 sReset
  logic [1:0] ctrlBits;

  // Word kind, same in both union views
  wordKindT inKind;
  assign inKind = hostInData.cfg.kind;

  // --------------------
  // Control register and push strobe
  // --------------------
  always_ff @(posedge sysClk or negedge rstN) begin
    if (!rstN) begin
      ctrlBits <= 2'b11;  // Both resets held after power up
      push     <= 1'b0;
    end else begin
      push <= 1'b0;  // Single cycle strobe
      if (hostInWrite) begin
        case (inKind)
          kindChip: begin
            // Dropped when the FIFO reports full
            push <= !fifoFull;
          end
          kindConfig: begin
            case (hostInData.cfg.regId)
              ctrlRegId: ctrlBits <= hostInData.cfg.data[1:0];
              nopRegId:  ;  // Nop fill word
              default:   ;  // Other registers not kept
            endcase
          end
          kindChannel: ;  // Channel words ignored
          default:     ;  // Kind 01 is undefined
        endcase
      end
    end
  end

  // --------------------
  // Chip word capture
  // --------------------
  // Payload only, qualified by push
  always_ff @(posedge sysClk) begin
    if (hostInWrite && inKind == kindChip) begin
      pushData.leaf    <= hostInData.chip.leaf;
      pushData.payload <= hostInData.chip.payload;
    end
  end

  // --------------------
  // Reset outputs
  // --------------------
  assign pReset   = ctrlBits[0];
  assign sReset   = ctrlBits[1];
  assign linkHold = |ctrlBits;  // Chip links frozen while either reset is up

endmodule

//--- design/wordFifo.sv
// Synchronous word FIFO
`timescale 1ns/100ps

module wordFifo #(
  parameter type wordT     = logic [31:0],
  parameter int  fifoDepth = 16  // Power of two
) (
  input  logic                       sysClk,
  input  logic                       rstN,
  // Write side
  input  logic                       push,
  input  wordT                       pushData,
  // Read side
  input  logic                       pop,
  output wordT                       popData,
  // Status
  output logic                       full,
  output logic                       empty,
  output logic [$clog2(fifoDepth):0] freeCount
);

  localparam int ptrW = $clog2(fifoDepth);
  localparam int cntW = ptrW + 1;

  wordT            mem [fifoDepth];
  logic [ptrW-1:0] wrPtr;  // Wraps on its own
  logic [ptrW-1:0] rdPtr;
  logic [cntW-1:0] count;  // Occupancy

  logic doPush;
  logic doPop;

  // Overflow and underflow are ignored
  assign doPush = push && (count != cntW'(fifoDepth));
  assign doPop  = pop && (count != '0);

  // --------------------
  // Pointers and count
  // --------------------
  always_ff @(posedge sysClk or negedge rstN) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) wrPtr <= wrPtr + 1'b1;
      if (doPop) rdPtr <= rdPtr + 1'b1;
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  // Storage
  always_ff @(posedge sysClk) begin
    if (doPush) mem[wrPtr] <= pushData;
  end

  assign popData = mem[rdPtr];  // Head word, valid while not empty

  // Full keeps one entry spare for a writer that pushes a cycle late
  assign full      = count >= cntW'(fifoDepth - 1);
  assign empty     = count == '0;
  assign freeCount = cntW'(fifoDepth) - count;

endmodule

//--- design/chipDownSender.sv
// Downstream chip link sender
`timescale 1ns/100ps

module chipDownSender
  import chipLinkPkg::*;
(
  input  logic     sysClk,
  input  logic     rstN,
  input  logic     linkHold,
  // Downstream FIFO
  input  logic     fifoEmpty,
  input  chipDownT fifoData,
  output logic     pop,
  // Chip link
  output logic     chipOutValid,
  output chipDownT chipOutData,
  input  logic     chipOutReady
);

  logic xfer;  // Word taken by the chip this cycle

  assign xfer = chipOutValid && chipOutReady;

  // Reload the output register when it is free or being emptied
  // Never start a new word during a hold
  assign pop = !fifoEmpty && !linkHold && (!chipOutValid || chipOutReady);

  // --------------------
  // Valid flag
  // --------------------
  always_ff @(posedge sysClk or negedge rstN) begin
    if (!rstN) begin
      chipOutValid <= 1'b0;
    end else if (pop) begin
      chipOutValid <= 1'b1;  // Next word, back to back with a transfer
    end else if (xfer) begin
      chipOutValid <= 1'b0;  // Drained, nothing to follow
    end
  end

  // --------------------
  // Output data
  // --------------------
  // Held stable until the transfer
  always_ff @(posedge sysClk) begin
    if (pop) chipOutData <= fifoData;
  end

endmodule

//--- design/chipUpPacker.sv
// Upstream chip word packer
`timescale 1ns/100ps

module chipUpPacker
  import chipLinkPkg::*;
#(
  parameter int fifoDepth = 16
) (
  input  logic                       sysClk,
  input  logic                       rstN,
  input  logic                       linkHold,
  // Chip link
  input  logic                       chipInValid,
  input  chipUpT                     chipInData,
  output logic                       chipInReady,
  // Upstream FIFO
  input  logic [$clog2(fifoDepth):0] freeCount,
  output logic                       push,
  output hostUpWordT                 pushData
);

  typedef enum logic [1:0] {
    packIdle,  // Waiting for a chip word
    packLo,    // Pushing bits 23..0
    packHi     // Pushing bits 33..24
  } packStateT;

  packStateT state;
  chipUpT    held;  // Chip word being split

  // Two free entries cover both halves
  assign chipInReady = !linkHold && (state == packIdle) && (freeCount >= 2);

  // --------------------
  // FSM
  // --------------------
  always_ff @(posedge sysClk or negedge rstN) begin
    if (!rstN) begin
      state <= packIdle;
    end else begin
      case (state)
        packIdle: if (chipInValid && chipInReady) state <= packLo;
        packLo:   state <= packHi;
        packHi:   state <= packIdle;
        default:  state <= packIdle;
      endcase
    end
  end

  // Capture on transfer
  always_ff @(posedge sysClk) begin
    if (chipInValid && chipInReady) held <= chipInData;
  end

  // --------------------
  // Host words
  // --------------------
  assign push            = (state == packLo) || (state == packHi);
  assign pushData.header = upHeader;
  assign pushData.body   = (state == packHi) ? {14'd0, held.hi} : held.lo;

endmodule

//--- design/bdHostCore.sv
// Host to chip bridge core
`timescale 1ns/100ps

module bdHostCore
  import hostWordPkg::*;
  import chipLinkPkg::*;
#(
  parameter int fifoDepth = 16
) (
  input  logic       sysClk,
  input  logic       rstN,
  // Host write side
  input  logic       hostInWrite,
  input  hostWordU   hostInData,
  output logic       hostInFull,
  // Host read side
  input  logic       hostOutRead,
  output hostUpWordT hostOutData,
  output logic       hostOutEmpty,
  // Chip downstream link
  output logic       chipOutValid,
  output chipDownT   chipOutData,
  input  logic       chipOutReady,
  // Chip upstream link
  input  logic       chipInValid,
  input  chipUpT     chipInData,
  output logic       chipInReady,
  // Chip resets
  output logic       pReset,
  output logic       sReset
);

  // --------------------
  // Downstream path
  // --------------------
  logic     linkHold;    // High while either reset is set
  logic     downPush;
  chipDownT downPushData;
  logic     downPop;
  logic     downEmpty;
  chipDownT downPopData;

  hostWordDecoder u_hostWordDecoder (
    .sysClk     (sysClk),
    .rstN       (rstN),
    .hostInWrite(hostInWrite),
    .hostInData (hostInData),
    .fifoFull   (hostInFull),
    .push       (downPush),
    .pushData   (downPushData),
    .pReset     (pReset),
    .sReset     (sReset),
    .linkHold   (linkHold)
  );

  wordFifo #(.wordT(chipDownT), .fifoDepth(fifoDepth)) u_downFifo (
    .sysClk   (sysClk),
    .rstN     (rstN),
    .push     (downPush),
    .pushData (downPushData),
    .pop      (downPop),
    .popData  (downPopData),
    .full     (hostInFull),  // Host write back-pressure
    .empty    (downEmpty),
    .freeCount()
  );

  chipDownSender u_chipDownSender (
    .sysClk      (sysClk),
    .rstN        (rstN),
    .linkHold    (linkHold),
    .fifoEmpty   (downEmpty),
    .fifoData    (downPopData),
    .pop         (downPop),
    .chipOutValid(chipOutValid),
    .chipOutData (chipOutData),
    .chipOutReady(chipOutReady)
  );

  // --------------------
  // Upstream path
  // --------------------
  logic                       upPush;
  hostUpWordT                 upPushData;
  logic [$clog2(fifoDepth):0] upFree;  // Free entries seen by the packer

  chipUpPacker #(.fifoDepth(fifoDepth)) u_chipUpPacker (
    .sysClk     (sysClk),
    .rstN       (rstN),
    .linkHold   (linkHold),
    .chipInValid(chipInValid),
    .chipInData (chipInData),
    .chipInReady(chipInReady),
    .freeCount  (upFree),
    .push       (upPush),
    .pushData   (upPushData)
  );

  wordFifo #(.wordT(hostUpWordT), .fifoDepth(fifoDepth)) u_upFifo (
    .sysClk   (sysClk),
    .rstN     (rstN),
    .push     (upPush),
    .pushData (upPushData),
    .pop      (hostOutRead),
    .popData  (hostOutData),
    .full     (),  // Packer paces itself on freeCount
    .empty    (hostOutEmpty),
    .freeCount(upFree)
  );

endmodule

//--- verification/chipLinkModels.sv
// Chip side link models
`timescale 1ns/100ps

// --------------------
// Downstream sink
// --------------------
module chipDownSink #(
  parameter int seedInit = 1
) (
  input  logic sysClk,
  input  logic rstN,
  output logic chipOutReady
);

  int   seed  = seedInit;
  int   pause = 0;     // Cycles left in a stall
  logic ready = 1'b0;

  assign chipOutReady = ready;

  always @(posedge sysClk) begin
    if (!rstN) begin
      ready <= 1'b0;
    end else if (pause > 0) begin
      pause <= pause - 1;
      ready <= 1'b0;
    end else if (($random(seed) & 15) == 0) begin
      pause <= 16 + ($random(seed) & 63);  // Long stall, fills the FIFO
      ready <= 1'b0;
    end else begin
      ready <= (($random(seed) & 3) != 0);  // Short gaps
    end
  end

endmodule

// --------------------
// Upstream source
// --------------------
module chipUpSource
  import chipLinkPkg::*;
#(
  parameter int seedInit = 1,
  parameter int numWords = 40
) (
  input  logic   sysClk,
  input  logic   rstN,
  input  logic   go,           // Start offering words
  output logic   chipInValid,
  output chipUpT chipInData,
  input  logic   chipInReady,
  output logic   done          // All words taken
);

  int          seed  = seedInit;
  int          gap   = 0;       // Idle cycles before the next offer
  int          sent  = 0;
  logic        valid = 1'b0;
  chipUpT      data  = '0;
  logic [63:0] rnd;

  assign chipInValid = valid;
  assign chipInData  = data;
  assign done        = (sent == numWords);

  always @(posedge sysClk) begin
    if (!rstN) begin
      valid <= 1'b0;
    end else if (valid && chipInReady) begin
      valid <= 1'b0;  // Taken at this edge
      sent  <= sent + 1;
      gap   <= $random(seed) & 7;
    end else if (!valid && go && sent < numWords) begin
      if (gap > 0) begin
        gap <= gap - 1;
      end else begin
        rnd = {$random(seed), $random(seed)};
        data  <= rnd[33:0];
        valid <= 1'b1;  // Held until taken
      end
    end
  end

endmodule

//--- verification/bdHostCore_tb.sv
// Bridge core testbench
`timescale 1ns/100ps

module bdHostCore_tb
  import hostWordPkg::*;
  import chipLinkPkg::*;
();

  localparam int fifoDepth   = 16;
  localparam int numHeld     = 8;   // Written during the first hold
  localparam int numBurst    = 60;
  localparam int numLate     = 4;   // Written during the second hold
  localparam int numDown     = numHeld + numBurst + numLate;
  localparam int numUp       = 40;  // Chip words upstream
  localparam int watchCycles = (numDown + 2 * numUp) * 40 + 1000;

  typedef hostUpWordT [1:0] upPairT;  // Low word in [0]

  logic       sysClk      = 1'b0;
  logic       rstN        = 1'b0;
  logic       hostInWrite = 1'b0;
  hostWordU   hostInData  = '0;
  logic       hostInFull;
  logic       hostOutRead = 1'b0;
  hostUpWordT hostOutData;
  logic       hostOutEmpty;
  logic       chipOutValid;
  chipDownT   chipOutData;
  logic       chipOutReady;
  logic       chipInValid;
  chipUpT     chipInData;
  logic       chipInReady;
  logic       pReset;
  logic       sReset;
  logic       srcGo = 1'b0;
  logic       srcDone;

  int         seed        = 32'hab63;
  int         readSeed    = 32'hab63 + 3;  // Host read pacing
  int         readPause   = 0;
  int         downWritten = 0;
  int         downChecked = 0;
  int         upChecked   = 0;
  logic       expectHold  = 1'b1;  // Links should be frozen
  chipDownT   downQ[$];
  hostUpWordT upQ[$];

  always #10 sysClk = ~sysClk;

  bdHostCore #(.fifoDepth(fifoDepth)) u_bdHostCore (
    .sysClk(sysClk), .rstN(rstN),
    .hostInWrite(hostInWrite), .hostInData(hostInData), .hostInFull(hostInFull),
    .hostOutRead(hostOutRead), .hostOutData(hostOutData), .hostOutEmpty(hostOutEmpty),
    .chipOutValid(chipOutValid), .chipOutData(chipOutData), .chipOutReady(chipOutReady),
    .chipInValid(chipInValid), .chipInData(chipInData), .chipInReady(chipInReady),
    .pReset(pReset), .sReset(sReset)
  );

  chipDownSink #(.seedInit(32'hab63 + 1)) u_sink (
    .sysClk(sysClk), .rstN(rstN), .chipOutReady(chipOutReady)
  );

  chipUpSource #(.seedInit(32'hab63 + 2), .numWords(numUp)) u_source (
    .sysClk(sysClk), .rstN(rstN), .go(srcGo), .chipInValid(chipInValid),
    .chipInData(chipInData), .chipInReady(chipInReady), .done(srcDone)
  );

  // --------------------
  // Reference functions
  // --------------------
  function automatic chipDownT expectedDown(input hostWordU w);
    logic [31:0] bits;
    bits = w;
    return {bits[29:24], bits[19:0]};  // Leaf, then payload
  endfunction

  function automatic upPairT expectedUp(input chipUpT w);
    logic [33:0] bits;
    upPairT      pair;
    bits = w;
    pair[0] = {8'hff, bits[23:0]};
    pair[1] = {8'hff, 14'd0, bits[33:24]};
    return pair;
  endfunction

  // --------------------
  // Failure and compare tasks
  // --------------------
  task automatic reportFailure(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic checkDown(input chipDownT got, input chipDownT exp);
    if (got !== exp)
      reportFailure($sformatf("Fail at %0d ns: chipOutData is %h, expected %h", $time, got, exp));
  endtask

  task automatic checkUp(input hostUpWordT got, input hostUpWordT exp);
    if (got !== exp)
      reportFailure($sformatf("Fail at %0d ns: hostOutData is %h, expected %h", $time, got, exp));
  endtask

  task automatic checkResets(input logic expP, input logic expS);
    if (pReset !== expP)
      reportFailure($sformatf("Fail at %0d ns: pReset is %b, expected %b", $time, pReset, expP));
    if (sReset !== expS)
      reportFailure($sformatf("Fail at %0d ns: sReset is %b, expected %b", $time, sReset, expS));
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp)
      reportFailure($sformatf("Fail at %0d ns: %s is %b, expected %b", $time, name, got, exp));
  endtask

  // --------------------
  // Host stimulus
  // --------------------
  function automatic hostWordU randomChipWord();
    hostWordU w;
    w = $random(seed);
    w.chip.kind = kindChip;
    return w;
  endfunction

  // 0 nop, 1 other register, 2 channel word
  function automatic hostWordU ignoredWord(input int sel);
    hostWordU w;
    w = $random(seed);
    if (sel == 2) begin
      w.cfg.kind = kindChannel;
    end else begin
      w.cfg.kind  = kindConfig;
      w.cfg.regId = (sel == 0) ? nopRegId : 6'(1 + ($random(seed) & 15));
    end
    return w;
  endfunction

  // Full is checked once the previous push has landed
  task automatic hostWrite(input hostWordU w);
    @(negedge sysClk);
    while (hostInFull) @(negedge sysClk);
    if (w.chip.kind == kindChip) begin
      downQ.push_back(expectedDown(w));
      downWritten++;
    end
    @(posedge sysClk);
    hostInWrite <= 1'b1;
    hostInData  <= w;
    @(posedge sysClk);  // Taken here
    hostInWrite <= 1'b0;
    @(posedge sysClk);  // Decoder push reaches the FIFO
  endtask

  task automatic writeCtrl(input logic [1:0] bits);
    hostWordU w;
    w = '0;
    w.cfg.kind  = kindConfig;
    w.cfg.regId = ctrlRegId;
    w.cfg.data  = {14'd0, bits};
    if (bits == 2'b00) expectHold = 1'b0;  // Free before the word lands
    hostWrite(w);
    @(negedge sysClk);
    expectHold = |bits;
    checkResets(bits[0], bits[1]);
  endtask

  // Host reads with random pauses
  always @(posedge sysClk) begin
    if (!rstN) begin
      hostOutRead <= 1'b0;
    end else if (readPause > 0) begin
      readPause   <= readPause - 1;
      hostOutRead <= 1'b0;
    end else if (($random(readSeed) & 31) == 0) begin
      readPause   <= 10 + ($random(readSeed) & 31);
      hostOutRead <= 1'b0;
    end else begin
      hostOutRead <= (($random(readSeed) & 3) != 0);
    end
  end

  // --------------------
  // Compare process
  // --------------------
  // Sampled at the falling edge, inputs move only on the rising one
  always @(negedge sysClk) begin : compareLoop
    upPairT pair;
    if (rstN) begin
      if (chipOutValid && chipOutReady) begin
        if (expectHold) begin
          reportFailure("A chip word was sent while the links were held");
        end else if (downQ.size() == 0) begin
          reportFailure("A chip word was sent with no command outstanding");
        end else begin
          checkDown(chipOutData, downQ.pop_front());
          downChecked++;
        end
      end
      if (expectHold && chipInReady)
        reportFailure("The packer is ready while the links are held");
      if (chipInValid && chipInReady) begin
        pair = expectedUp(chipInData);
        upQ.push_back(pair[0]);
        upQ.push_back(pair[1]);
      end
      if (hostOutRead && !hostOutEmpty) begin
        if (upQ.size() == 0) begin
          reportFailure("The host read a word that the chip never sent");
        end else begin
          checkUp(hostOutData, upQ.pop_front());
          upChecked++;
        end
      end
    end
  end

  initial begin : watchdog
    repeat (watchCycles) @(posedge sysClk);
    reportFailure($sformatf("Timeout, stalled at %0d of %0d chip words and %0d of %0d host words",
                            downChecked, numDown, upChecked, 2 * numUp));
  end

  // --------------------
  // Main sequence
  // --------------------
  initial begin : mainSequence
    int sel;
    repeat (4) @(posedge sysClk);
    rstN  <= 1'b1;
    srcGo <= 1'b1;  // Source waits on the held link
    @(negedge sysClk);
    checkResets(1'b1, 1'b1);
    checkFlag("hostInFull", hostInFull, 1'b0);
    checkFlag("hostOutEmpty", hostOutEmpty, 1'b1);
    checkFlag("chipOutValid", chipOutValid, 1'b0);
    checkFlag("chipInReady", chipInReady, 1'b0);

    repeat (numHeld) hostWrite(randomChipWord());  // Parked in the FIFO
    repeat (30) @(posedge sysClk);
    writeCtrl(2'b00);

    // Bursts mixed with words that must be ignored
    while (downWritten < numHeld + numBurst) begin
      sel = $random(seed) & 7;
      if (sel < 3) begin
        hostWrite(ignoredWord(sel));
        @(negedge sysClk);
        checkResets(1'b0, 1'b0);
      end else begin
        hostWrite(randomChipWord());
      end
      repeat ($random(seed) & 3) @(posedge sysClk);
    end
    wait (downChecked == downWritten && srcDone && upChecked == 2 * numUp);

    // Second hold, sReset only
    writeCtrl(2'b10);
    repeat (numLate) hostWrite(randomChipWord());
    repeat (30) @(posedge sysClk);
    writeCtrl(2'b00);
    wait (downChecked == downWritten);
    repeat (10) @(posedge sysClk);

    if (downQ.size() == 0 && upQ.size() == 0 && downChecked == numDown) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      reportFailure("Words were left unchecked at the end of the run");
    end
  end

endmodule

//--- verilog.f
common/hostWordPkg.sv
common/chipLinkPkg.sv
design/hostWordDecoder.sv
design/wordFifo.sv
design/chipDownSender.sv
design/chipUpPacker.sv
design/bdHostCore.sv
verification/chipLinkModels.sv
verification/bdHostCore_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the bridge core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
  --top-module bdHostCore_tb -f verilog.f \
  --Mdir obj_dir -o simBdHostCore
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simBdHostCore
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

echo "Simulation passed"
exit 0
